/* vlog.f */
rtl/zmips_isa_pkg.sv
rtl/zmips_pipe_pkg.sv
rtl/zmips_fetch.sv
rtl/zmips_decode.sv
rtl/zmips_regfile.sv
rtl/zmips_alu.sv
rtl/zmips_execute.sv
rtl/zmips_mem_wb.sv
rtl/zmips_hazard.sv
rtl/zmips_core.sv
tests/zmips_tb_asserts.sv
tests/zmips_tb.sv

/* run.sh */
#!/bin/sh
# Build the zmips testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module zmips_tb -o zmips_sim

out=$(./obj_dir/zmips_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "=== PASS ==="; then
    exit 0
else
    exit 1
fi

/* tests/zmips_tb.sv */
// Testbench for zmips_core: clock, memories, program assembly, directed tests, pass/fail
`timescale 1ns/1ns

module zmips_tb
    import zmips_isa_pkg::*;
;
    localparam logic [31:0] DONE_ADDR = 32'h0000_0FFC; // Store here ends a program
    // R ops built from the OP_SHIFT, OP_WB and OP_MEM bit positions
    localparam logic [5:0] OP_ALU  = 6'b000100;
    localparam logic [5:0] OP_SH   = 6'b000101;
    localparam logic [5:0] OP_LD   = 6'b001100;
    localparam logic [5:0] OP_ST   = 6'b001000;
    localparam logic [5:0] OP_FLAG = 6'b000000; // No writeback, flags only

    logic        clk, rst, d_rd, d_wr;
    logic [31:0] i_data, i_addr, d_addr, d_data_o, d_data_i;
    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] dinit [1024];  // Data memory image loaded during reset
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$], exp_data [$];
    logic [31:0] st_addr [$], st_data [$];
    logic [31:0] exp_ld [$], ld_addr [$]; // Load addresses, expected and seen on d_rd
    int          st_cyc [$];
    logic [31:0] rm [32];       // Register model
    logic        fz, fc, fn;    // Flag model
    int          cyc;
    logic        done_seen;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    assign i_data   = imem[i_addr[9:2]];  // Both memories answer combinationally
    assign d_data_i = dmem[d_addr[11:2]];

    zmips_core #(.RESET_PC(32'h0)) u_dut (
        .clk, .rst, .i_data, .i_addr, .d_addr, .d_data_o, .d_data_i, .d_rd, .d_wr
    );

    // Data memory write side and store recorder, cycle 0 is the first after reset
    always @(posedge clk) begin
        if (rst) begin
            cyc       <= 0;
            done_seen <= 1'b0;
            st_addr.delete();
            st_data.delete();
            st_cyc.delete();
            ld_addr.delete();
            for (int i = 0; i < 1024; i++) dmem[i] <= dinit[i];
        end else begin
            cyc <= cyc + 1;
            if (d_rd) ld_addr.push_back(d_addr);
            if (d_wr) begin
                dmem[d_addr[11:2]] <= d_data_o;
                if (d_addr == DONE_ADDR) begin
                    done_seen <= 1'b1;
                end else begin
                    st_addr.push_back(d_addr);
                    st_data.push_back(d_data_o);
                    st_cyc.push_back(cyc);
                end
            end
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rs, rt, rd,
                                         input logic [4:0] sh, input logic [2:0] code,
                                         input logic [2:0] en);
        return {op, rs, rt, rd, sh, code, en};
    endfunction

    // Reference ALU, written from the instruction rules
    function automatic logic [31:0] alu_ref(input bit sh_grp, input logic [2:0] code,
                                            input logic [31:0] a, b, input logic [4:0] sh);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> sh;  // Arithmetic shift via sign-extended word
        if (sh_grp) begin
            case (code)
                SH_SLL:  return a << sh;
                SH_SRL:  return a >> sh;
                SH_SRA:  return ext[31:0];
                default: return a;
            endcase
        end
        case (code)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 32'd1;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_NOR: return ~(a | b);
            default: return a;
        endcase
    endfunction

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_ld.delete();
        for (int i = 0; i < 32; i++) rm[i] = 32'h0;
        for (int i = 0; i < 1024; i++) dinit[i] = 32'h5A00_0000 ^ (i * 32'h9E37_79B1);
        {fz, fc, fn} = 3'b000;
    endtask

    task automatic set_imm(input logic [25:0] v);
        prog.push_back({FMT_IMM, 4'b0000, v});
        rm[0] = {{6{v[25]}}, v};
    endtask

    task automatic alu_step(input int rd, rs, rt, input bit sh_grp, input logic [2:0] code,
                            input logic [4:0] sh);
        prog.push_back(enc_r(sh_grp ? OP_SH : OP_ALU, 5'(rs), 5'(rt), 5'(rd), sh, code, 3'b0));
        rm[rd] = alu_ref(sh_grp, code, rm[rs], rm[rt], sh);
    endtask

    task automatic store_reg(input logic [31:0] addr, input int r, input bit expect_it);
        set_imm(addr[25:0]);
        prog.push_back(enc_r(OP_ST, 5'd0, 5'(r), 5'd0, 5'd0, ALU_PASS_A, 3'b0));
        if (expect_it) begin
            exp_addr.push_back(addr);
            exp_data.push_back(rm[r]);
        end
    endtask

    task automatic load_reg(input int rd, input logic [31:0] addr, input logic [31:0] value);
        set_imm(addr[25:0]);
        prog.push_back(enc_r(OP_LD, 5'd0, 5'd0, 5'(rd), 5'd0, ALU_PASS_A, 3'b0));
        rm[rd] = value;
        exp_ld.push_back(addr);
    endtask

    task automatic finish_program();
        store_reg(DONE_ADDR, 0, 1'b0);
        prog.push_back({FMT_J, 30'(prog.size())}); // Spin on itself
    endtask

    task automatic run_program(input string name);
        int n;
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < 256; i++) imem[i] = (i < prog.size()) ? prog[i] : NOP_WORD;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check({name, " first fetch address"}, i_addr, 32'h0);
        n = 0;
        while (!done_seen && n < 600) begin
            @(negedge clk);
            n++;
        end
        if (!done_seen) begin
            $display("Timeout: %s never stored to the DONE address", name);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
        check({name, " store count"}, st_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size(); i++) begin
            check({name, " store address"}, st_addr[i], exp_addr[i]);
            check({name, " store data"}, st_data[i], exp_data[i]);
        end
        check({name, " load count"}, ld_addr.size(), exp_ld.size());
        for (int i = 0; i < exp_ld.size(); i++) begin
            check({name, " load address"}, ld_addr[i], exp_ld[i]);
        end
    endtask

    task automatic test_reset();
        new_program();
        repeat (3) prog.push_back(NOP_WORD);
        store_reg(32'h40, 0, 1'b1); // Store at word 4 reaches MEM in cycle 7
        finish_program();
        run_program("reset");
        check("reset first store cycle", st_cyc[0], 7);
    endtask

    task automatic test_alu();
        logic [4:0] s1, s2, s3;
        new_program();
        s1 = 5'($urandom);
        s2 = 5'($urandom);
        s3 = 5'($urandom);
        dinit[64] = $urandom;
        dinit[65] = $urandom;
        load_reg(1, 32'h100, dinit[64]);
        load_reg(2, 32'h104, dinit[65]);
        alu_step(3, 1, 2, 0, ALU_ADD, 0);  // Each op uses the one before it
        alu_step(4, 3, 2, 0, ALU_SUB, 0);
        alu_step(5, 4, 1, 0, ALU_AND, 0);
        alu_step(6, 5, 2, 0, ALU_OR, 0);
        alu_step(7, 6, 1, 0, ALU_XOR, 0);
        alu_step(8, 7, 2, 0, ALU_NOR, 0);
        alu_step(9, 8, 0, 1, SH_SLL, s1);
        alu_step(10, 9, 0, 1, SH_SRL, s2);
        alu_step(11, 8, 0, 1, SH_SRA, s3);
        alu_step(12, 11, 2, 0, ALU_PASS_A, 0);
        alu_step(13, 12, 0, 1, 3'b011, s1); // Spare shift code passes a
        for (int r = 3; r <= 13; r++) store_reg(32'h200 + 4 * (r - 3), r, 1'b1);
        finish_program();
        run_program("alu");
    endtask

    task automatic test_mem();
        new_program();
        set_imm(26'($urandom));
        alu_step(1, 0, 0, 0, ALU_PASS_A, 0);
        store_reg(32'h300, 1, 1'b1);
        load_reg(2, 32'h300, rm[1]);       // Same address, r0 already holds it
        prog.delete(prog.size() - 2);      // Drop the redundant address load
        alu_step(3, 2, 1, 0, ALU_ADD, 0);  // Load-use, one stall
        store_reg(32'h304, 3, 1'b1);
        finish_program();
        run_program("load/store");
        check("load-use store cycle", st_cyc[1], 11);
    endtask

    task automatic test_branch();
        logic [25:0] a26, b26;
        logic [2:0]  en;
        logic [1:0]  cc;
        logic        pol, take;
        logic [31:0] d, br;
        new_program();
        for (int i = 0; i < 8; i++) begin
            cc  = 2'(i / 2);
            pol = i[0];
            en  = (i == 5) ? 3'b110 : 3'b111; // N kept from the case before
            a26 = 26'($urandom);
            a26 = {{20{a26[5]}}, a26[5:0]};
            b26 = 26'($urandom);
            b26 = (i % 3 == 1) ? a26 : {{20{b26[5]}}, b26[5:0]};
            set_imm(a26);
            alu_step(1, 0, 0, 0, ALU_PASS_A, 0);
            set_imm(b26);
            alu_step(2, 0, 0, 0, ALU_PASS_A, 0);
            prog.push_back(enc_r(OP_FLAG, 5'd1, 5'd2, 5'd0, 5'd0, ALU_SUB, en));
            d = rm[1] - rm[2];
            if (en[FN_ZEN]) fz = (d == 32'h0);
            if (en[FN_CEN]) fc = (rm[1] >= rm[2]);
            if (en[FN_NEN]) fn = d[31];
            if (!pol) begin
                prog.push_back(NOP_WORD);  // Odd cases sit right behind the SUB
                prog.push_back(NOP_WORD);
            end
            case (cc)
                CC_Z:    take = (fz == pol);
                CC_C:    take = (fc == pol);
                CC_N:    take = (fn == pol);
                default: take = 1'b1;
            endcase
            br = prog.size() * 4;
            prog.push_back({FMT_BR, pol, 1'b0, cc, 26'd3}); // Taken path at br+16
            store_reg(32'h404 + 8 * i, 0, !take);
            prog.push_back({FMT_J, 30'((br + 24) >> 2)});
            store_reg(32'h400 + 8 * i, 0, take);
        end
        finish_program();
        run_program("branch");
    endtask

    task automatic test_jump();
        new_program();
        store_reg(32'h500, 0, 1'b1);
        prog.push_back({FMT_J, 30'(prog.size() + 3)}); // Over the next two words
        store_reg(32'h504, 0, 1'b0);
        store_reg(32'h508, 0, 1'b1);
        finish_program();
        run_program("jump");
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(32'hdc61_ca60));
        for (int i = 0; i < 1024; i++) dinit[i] = 32'h0;
        for (int i = 0; i < 256; i++) imem[i] = NOP_WORD;
        test_reset();
        test_alu();
        test_mem();
        test_branch();
        test_jump();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* tests/zmips_tb_asserts.sv */
// Concurrent assertions on the zmips_core data and instruction ports, bound to the core
`timescale 1ns/1ns

module zmips_core_asserts (
    input logic        clk,
    input logic        rst,
    input logic        d_rd,
    input logic        d_wr,
    input logic [31:0] i_addr
);

    // A data access is a read or a write, never both
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(d_rd && d_wr))
        else $error("d_rd and d_wr high in the same cycle");

    // Strobes quiet through reset and in the cycle after
    a_quiet_in_reset: assert property (@(posedge clk) rst |=> (!d_rd && !d_wr))
        else $error("data strobe active during or right after reset");

    a_pc_known: assert property (@(posedge clk) !rst |-> !$isunknown(i_addr))
        else $error("i_addr unknown after reset");

endmodule

bind zmips_core zmips_core_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .d_rd   (d_rd),
    .d_wr   (d_wr),
    .i_addr (i_addr)
);

/* rtl/zmips_core.sv */
// Five-stage core top level connecting fetch, decode, register file, execute, memory and hazard
`timescale 1ns/1ns

module zmips_core
    import zmips_pipe_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] i_data,
    output logic [XLEN-1:0] i_addr,
    output logic [XLEN-1:0] d_addr,
    output logic [XLEN-1:0] d_data_o,
    input  logic [XLEN-1:0] d_data_i,
    output logic            d_rd,
    output logic            d_wr
);

    logic              stall, redirect;
    logic [XLEN-1:0]   target_pc, id_pc, id_ir;
    logic [REG_AW-1:0] rs, rt;
    logic [XLEN-1:0]   rf_rs_data, rf_rt_data;
    logic [2:0]        flags_now, flags_next, flags_en;
    logic [XLEN-1:0]   ex_a, ex_b, ex_imm;     // ID/EX
    logic [REG_AW-1:0] ex_rs, ex_rt, ex_rd;
    logic [4:0]        ex_shamt;
    logic [2:0]        ex_alu_code, ex_flag_en;
    logic              ex_shift, ex_use_imm, ex_mem_rd, ex_mem_wr, ex_we;
    logic [FWD_W-1:0]  fwd_a, fwd_b;
    logic [XLEN-1:0]   mem_result, mem_store_data; // EX/MEM
    logic              mem_rd, mem_wr, mem_we;
    logic [REG_AW-1:0] mem_rdst;
    logic              wb_we;                  // MEM/WB
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;

    zmips_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .rst, .stall, .redirect, .target_pc, .i_data,
        .i_addr, .id_pc, .id_ir
    );

    zmips_decode u_decode (
        .clk, .rst, .id_pc, .id_ir, .stall, .rf_rs_data, .rf_rt_data,
        .ex_flags_now  (flags_now),
        .ex_flags_next (flags_next),
        .ex_flags_en   (flags_en),
        .rs, .rt, .redirect, .target_pc,
        .ex_a, .ex_b, .ex_rs, .ex_rt, .ex_rd, .ex_imm, .ex_shamt, .ex_alu_code,
        .ex_shift, .ex_use_imm, .ex_mem_rd, .ex_mem_wr, .ex_we, .ex_flag_en
    );

    zmips_regfile u_regfile (
        .clk, .rst, .rs, .rt, .wb_we, .wb_rd, .wb_data,
        .rs_data (rf_rs_data),
        .rt_data (rf_rt_data)
    );

    zmips_execute u_execute (
        .clk, .rst, .ex_a, .ex_b, .ex_rd, .ex_imm, .ex_shamt, .ex_alu_code, .ex_shift,
        .ex_use_imm, .ex_mem_rd, .ex_mem_wr, .ex_we, .ex_flag_en, .fwd_a, .fwd_b, .wb_data,
        .flags_now, .flags_next, .flags_en,
        .mem_result, .mem_store_data, .mem_rd, .mem_wr, .mem_we, .mem_rdst
    );

    zmips_mem_wb u_mem_wb (
        .clk, .rst, .mem_result, .mem_store_data, .mem_rd, .mem_wr, .mem_we, .mem_rdst,
        .d_data_i, .d_addr, .d_data_o, .d_rd, .d_wr, .wb_we, .wb_rd, .wb_data
    );

    zmips_hazard u_hazard (
        .id_rs (rs),
        .id_rt (rt),
        .ex_mem_rd, .ex_rd, .ex_rs, .ex_rt, .mem_we, .mem_rdst, .wb_we, .wb_rd,
        .stall, .fwd_a, .fwd_b
    );

endmodule

/* rtl/zmips_hazard.sv */
// Operand forwarding selects and load-use stall detection
`timescale 1ns/1ns

module zmips_hazard
    import zmips_pipe_pkg::*;
(
    input  logic [REG_AW-1:0] id_rs,
    input  logic [REG_AW-1:0] id_rt,
    input  logic              ex_mem_rd,  // Op in EX is a load
    input  logic [REG_AW-1:0] ex_rd,
    input  logic [REG_AW-1:0] ex_rs,
    input  logic [REG_AW-1:0] ex_rt,
    input  logic              mem_we,
    input  logic [REG_AW-1:0] mem_rdst,
    input  logic              wb_we,
    input  logic [REG_AW-1:0] wb_rd,
    output logic              stall,
    output logic [FWD_W-1:0]  fwd_a,
    output logic [FWD_W-1:0]  fwd_b
);

    // A destination equal to the source is the only match condition
    function automatic logic [FWD_W-1:0] src_sel(input logic [REG_AW-1:0] src,
                                                 input logic mem_wr_en,
                                                 input logic [REG_AW-1:0] mem_dst,
                                                 input logic wb_wr_en,
                                                 input logic [REG_AW-1:0] wb_dst);
        if (mem_wr_en && mem_dst == src) return FWD_MEM;
        if (wb_wr_en && wb_dst == src) return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a = src_sel(ex_rs, mem_we, mem_rdst, wb_we, wb_rd);
    assign fwd_b = src_sel(ex_rt, mem_we, mem_rdst, wb_we, wb_rd);

    // Load data is only ready in WB, hold the user one cycle
    assign stall = ex_mem_rd && (ex_rd == id_rs || ex_rd == id_rt);

endmodule

/* rtl/zmips_mem_wb.sv */
// Data memory port, MEM/WB register, writeback data select
`timescale 1ns/1ns

module zmips_mem_wb (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_result,
    input  logic [31:0] mem_store_data,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  logic        mem_we,
    input  logic [4:0]  mem_rdst,
    input  logic [31:0] d_data_i,
    output logic [31:0] d_addr,
    output logic [31:0] d_data_o,
    output logic        d_rd,
    output logic        d_wr,
    output logic        wb_we,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic [31:0] wb_load, wb_alu;
    logic        wb_is_load;

    // Combinational strobes, store lands at the edge closing MEM
    assign d_addr   = mem_result;
    assign d_data_o = mem_store_data;
    assign d_rd     = mem_rd;
    assign d_wr     = mem_wr;

    always_ff @(posedge clk) begin
        wb_load <= d_data_i;
        wb_alu  <= mem_result;
        wb_rd   <= mem_rdst;
        if (rst) begin
            wb_we      <= 1'b0;
            wb_is_load <= 1'b0;
        end else begin
            wb_we      <= mem_we;
            wb_is_load <= mem_rd;
        end
    end

    assign wb_data = wb_is_load ? wb_load : wb_alu;

endmodule

/* rtl/zmips_execute.sv */
// Operand forwarding muxes, ALU, Z/C/N flag registers, EX/MEM register
`timescale 1ns/1ns

module zmips_execute
    import zmips_isa_pkg::*;
    import zmips_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [XLEN-1:0]   ex_a,
    input  logic [XLEN-1:0]   ex_b,
    input  logic [REG_AW-1:0] ex_rd,
    input  logic [XLEN-1:0]   ex_imm,
    input  logic [4:0]        ex_shamt,
    input  logic [2:0]        ex_alu_code,
    input  logic              ex_shift,
    input  logic              ex_use_imm,
    input  logic              ex_mem_rd,
    input  logic              ex_mem_wr,
    input  logic              ex_we,
    input  logic [2:0]        ex_flag_en,
    input  logic [FWD_W-1:0]  fwd_a,
    input  logic [FWD_W-1:0]  fwd_b,
    input  logic [XLEN-1:0]   wb_data,
    output logic [2:0]        flags_now,
    output logic [2:0]        flags_next,
    output logic [2:0]        flags_en,
    output logic [XLEN-1:0]   mem_result,
    output logic [XLEN-1:0]   mem_store_data,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic              mem_we,
    output logic [REG_AW-1:0] mem_rdst
);

    logic [XLEN-1:0] pre_a, alu_a, alu_b, alu_y;
    logic            alu_zero, alu_carry;

    // Newest value wins, EX/MEM over MEM/WB
    function automatic logic [XLEN-1:0] fwd_mux(input logic [FWD_W-1:0] sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] mem_val,
                                                input logic [XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign pre_a = fwd_mux(fwd_a, ex_a, mem_result, wb_data);
    assign alu_a = ex_use_imm ? ex_imm : pre_a;  // Immediate load passes imm through
    assign alu_b = fwd_mux(fwd_b, ex_b, mem_result, wb_data);

    zmips_alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .code  (ex_alu_code),
        .shift (ex_shift),
        .shamt (ex_shamt),
        .y     (alu_y),
        .zero  (alu_zero),
        .carry (alu_carry)
    );

    always_comb begin
        flags_next[FN_ZEN] = alu_zero;
        flags_next[FN_CEN] = alu_carry;
        flags_next[FN_NEN] = alu_y[XLEN-1];
    end
    assign flags_en = ex_flag_en; // Decode uses these for branch flag forwarding

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_now <= 3'b000;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (flags_en[i]) flags_now[i] <= flags_next[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= alu_y;   // Also the memory address
        mem_store_data <= alu_b;
        mem_rdst       <= ex_rd;
        if (rst) begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            mem_rd <= ex_mem_rd;
            mem_wr <= ex_mem_wr;
            mem_we <= ex_we;
        end
    end

endmodule

/* rtl/zmips_alu.sv */
// ALU with add, subtract and logic ops, barrel shifter, zero and carry outputs
`timescale 1ns/1ns

module zmips_alu
    import zmips_isa_pkg::*;
(
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [2:0]  code,
    input  logic        shift,  // Shift group select
    input  logic [4:0]  shamt,
    output logic [31:0] y,
    output logic        zero,
    output logic        carry
);

    logic [32:0] sum;
    logic [32:0] diff;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b}; // Bit 32 is the borrow

    always_comb begin
        carry = 1'b0;
        if (shift) begin
            case (code)
                SH_SLL:  y = a << shamt;
                SH_SRL:  y = a >> shamt;
                SH_SRA:  y = $signed(a) >>> shamt;
                default: y = a;
            endcase
        end else begin
            case (code)
                ALU_ADD: begin
                    y     = sum[31:0];
                    carry = sum[32];
                end
                ALU_SUB: begin
                    y     = diff[31:0];
                    carry = ~diff[32]; // Set when a >= b unsigned
                end
                ALU_AND: y = a & b;
                ALU_OR:  y = a | b;
                ALU_XOR: y = a ^ b;
                ALU_NOR: y = ~(a | b);
                default: y = a;   // ALU_PASS_A and the spare code
            endcase
        end
    end

    assign zero = (y == 32'h0);

endmodule

/* rtl/zmips_regfile.sv */
// Register file, 32 by 32 bits, two read ports, one write port, write-through bypass
`timescale 1ns/1ns

module zmips_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic        wb_we,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32]; // r0 is an ordinary register

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= 32'h0;
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write is seen by decode
    assign rs_data = (wb_we && wb_rd == rs) ? wb_data : regs[rs];
    assign rt_data = (wb_we && wb_rd == rt) ? wb_data : regs[rt];

endmodule

/* rtl/zmips_decode.sv */
// Field decode, branch and jump targets, branch decision, control generation, ID/EX register
`timescale 1ns/1ns

module zmips_decode
    import zmips_isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] id_pc,
    input  logic [31:0] id_ir,
    input  logic        stall,
    input  logic [31:0] rf_rs_data,
    input  logic [31:0] rf_rt_data,
    input  logic [2:0]  ex_flags_now,  // Z/C/N registers
    input  logic [2:0]  ex_flags_next, // Flags produced by the op in EX
    input  logic [2:0]  ex_flags_en,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic        redirect,
    output logic [31:0] target_pc,
    output logic [31:0] ex_a,
    output logic [31:0] ex_b,
    output logic [4:0]  ex_rs,
    output logic [4:0]  ex_rt,
    output logic [4:0]  ex_rd,
    output logic [31:0] ex_imm,
    output logic [4:0]  ex_shamt,
    output logic [2:0]  ex_alu_code,
    output logic        ex_shift,
    output logic        ex_use_imm,
    output logic        ex_mem_rd,
    output logic        ex_mem_wr,
    output logic        ex_we,
    output logic [2:0]  ex_flag_en
);

    instr_t      ir;
    logic        is_r, is_imm, is_br, is_j;
    logic [31:0] imm_se;
    logic [31:0] br_target;
    logic [2:0]  flags;      // Flags as they stand after the op in EX
    logic        take;
    logic        bubble;

    assign ir     = id_ir;
    assign is_r   = (ir.j.jop == FMT_R);
    assign is_imm = (ir.j.jop == FMT_IMM);
    assign is_br  = (ir.j.jop == FMT_BR);
    assign is_j   = (ir.j.jop == FMT_J);

    assign rs = ir.r.rs; // Register file read addresses
    assign rt = ir.r.rt;

    assign imm_se    = {{6{ir.i.imm[25]}}, ir.i.imm};
    assign br_target = id_pc + {imm_se[29:0], 2'b00};

    // Per-flag forward from EX where that op updates it
    assign flags = (ex_flags_en & ex_flags_next) | (~ex_flags_en & ex_flags_now);

    always_comb begin
        case (ir.i.cc)
            CC_Z:    take = (flags[FN_ZEN] == ir.i.iop[1]);
            CC_C:    take = (flags[FN_CEN] == ir.i.iop[1]);
            CC_N:    take = (flags[FN_NEN] == ir.i.iop[1]);
            default: take = 1'b1; // CC_ALWAYS
        endcase
    end

    // Not taken still redirects, to id_pc, so every branch costs one bubble
    assign redirect  = (is_br | is_j) & ~stall;
    assign target_pc = is_j ? {ir.j.addr, 2'b00} : (take ? br_target : id_pc);

    assign bubble = stall | is_br | is_j;

    always_ff @(posedge clk) begin
        ex_a        <= rf_rs_data;
        ex_b        <= rf_rt_data;
        ex_rs       <= ir.r.rs;
        ex_rt       <= ir.r.rt;
        ex_rd       <= is_imm ? 5'd0 : ir.r.rd;  // Immediate always lands in r0
        ex_imm      <= imm_se;
        ex_shamt    <= ir.r.shamt;
        ex_alu_code <= is_imm ? ALU_PASS_A : ir.r.funct[5:3];
        ex_shift    <= is_r & ir.r.op[OP_SHIFT];
        if (rst || bubble) begin
            ex_use_imm <= 1'b0;
            ex_mem_rd  <= 1'b0;
            ex_mem_wr  <= 1'b0;
            ex_we      <= 1'b0;
            ex_flag_en <= 3'b000;
        end else begin
            ex_use_imm <= is_imm;
            ex_mem_rd  <= is_r & ir.r.op[OP_MEM] & ir.r.op[OP_WB];  // Load
            ex_mem_wr  <= is_r & ir.r.op[OP_MEM] & ~ir.r.op[OP_WB]; // Store
            ex_we      <= is_imm | (is_r & ir.r.op[OP_WB]);
            ex_flag_en <= is_r ? ir.r.funct[FN_ZEN:FN_NEN] : 3'b000;
        end
    end

endmodule

/* rtl/zmips_fetch.sv */
// Program counter and IF/ID register with stall hold and redirect squash
`timescale 1ns/1ns

module zmips_fetch
    import zmips_isa_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] target_pc,
    input  logic [31:0] i_data,
    output logic [31:0] i_addr,
    output logic [31:0] id_pc,   // Address of the fetched word plus 4
    output logic [31:0] id_ir
);

    logic [31:0] pc;
    logic [31:0] pc_inc;

    assign pc_inc = pc + 32'd4;
    assign i_addr = pc;          // Instruction port is combinational

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= RESET_PC;
            id_ir <= NOP_WORD;
        end else if (!stall) begin
            if (redirect) begin
                pc    <= target_pc;
                id_ir <= NOP_WORD;   // Drop the word fetched behind the branch
            end else begin
                pc    <= pc_inc;
                id_ir <= i_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) id_pc <= pc_inc; // Return address for relative branches
    end

endmodule

/* rtl/zmips_pipe_pkg.sv */
// Operand forwarding select codes, register index and data widths
package zmips_pipe_pkg;

    localparam int FWD_W = 2;

    // Source of an execute operand
    localparam logic [FWD_W-1:0] FWD_REG = 2'b00; // Value read in decode
    localparam logic [FWD_W-1:0] FWD_WB  = 2'b01; // MEM/WB writeback value
    localparam logic [FWD_W-1:0] FWD_MEM = 2'b10; // EX/MEM ALU result

    localparam int REG_AW = 5;
    localparam int XLEN   = 32;

endpackage

/* rtl/zmips_isa_pkg.sv */
// Instruction formats, field bit positions, ALU, shift and branch codes, instruction union
package zmips_isa_pkg;

    // Top two bits of every word select the format
    localparam logic [1:0] FMT_R   = 2'b00;
    localparam logic [1:0] FMT_IMM = 2'b01; // Sign-extended immediate into r0
    localparam logic [1:0] FMT_BR  = 2'b10; // Conditional branch, PC relative
    localparam logic [1:0] FMT_J   = 2'b11; // Absolute jump

    // Bits of the R-format op field
    localparam int OP_SHIFT = 0; // Shift group instead of logic/arith group
    localparam int OP_WB    = 2; // Write rd, or load when OP_MEM is set
    localparam int OP_MEM   = 3; // Memory access

    // Flag enables in funct, the ALU code sits above them in bits 5..3
    localparam int FN_ZEN = 2;
    localparam int FN_CEN = 1;
    localparam int FN_NEN = 0;

    // ALU codes, OP_SHIFT clear
    localparam logic [2:0] ALU_ADD    = 3'b000;
    localparam logic [2:0] ALU_SUB    = 3'b001;
    localparam logic [2:0] ALU_AND    = 3'b010;
    localparam logic [2:0] ALU_OR     = 3'b011;
    localparam logic [2:0] ALU_XOR    = 3'b100;
    localparam logic [2:0] ALU_NOR    = 3'b101;
    localparam logic [2:0] ALU_PASS_A = 3'b111;

    // Shift codes, OP_SHIFT set; the rest pass a through
    localparam logic [2:0] SH_SLL = 3'b000;
    localparam logic [2:0] SH_SRL = 3'b001;
    localparam logic [2:0] SH_SRA = 3'b010;

    // Branch condition select
    localparam logic [1:0] CC_Z      = 2'b00;
    localparam logic [1:0] CC_C      = 2'b01;
    localparam logic [1:0] CC_N      = 2'b10;
    localparam logic [1:0] CC_ALWAYS = 2'b11;

    localparam logic [31:0] NOP_WORD = 32'h0000_0000; // R op with no write, no flags

    // One instruction word seen three ways
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [3:0]  iop;   // Bit 29 is the branch polarity
            logic [1:0]  cc;
            logic [25:0] imm;
        } i;
        struct packed {
            logic [1:0]  jop;
            logic [29:0] addr;  // Word address of the target
        } j;
    } instr_t;

endpackage
